// File: project.f
+incdir+testbench
hw/pip_types.sv
hw/inst_decoder.sv
hw/fwd_table.sv
hw/rob_alloc.sv
hw/dispatch_stage.sv
hw/issue_queue.sv
hw/dispatch_top.sv
testbench/dispatch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dispatch testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module dispatch_tb -f project.f -o dispatch_sim \
  && ./obj_dir/dispatch_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '\*\* FAIL \*\*' sim.log && exit 1 || grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

// File: testbench/dispatch_vectors.svh
// each row holds lane words 0..3, lane pcs 0..3, the valid mask (bit i is lane i),
// issue_ready, a retire pulse and a flag for random pc and immediate bits
localparam int N_ROWS = 15;

row_t vectors [N_ROWS] = '{
  '{{32'h0, 32'h0, 32'h0, 32'h0}, {32'h0, 32'h0, 32'h0, 32'h0}, 4'b0000, 1'b1, 1'b1, 1'b0},
  '{{32'h002081b3, 32'hffb18213, 32'h00822283, 32'hfe51ae23},
    {32'h100, 32'h104, 32'h108, 32'h10c}, 4'b1111, 1'b1, 1'b0, 1'b0},
  '{{32'h8e3086e3, 32'habcde337, 32'h800000ef, 32'h00000f7f},
    {32'h110, 32'h114, 32'h118, 32'h11c}, 4'b1111, 1'b1, 1'b0, 1'b0},
  '{{32'h00108013, 32'h002083b3, 32'h00138393, 32'h00738433},
    {32'h120, 32'h124, 32'h128, 32'h12c}, 4'b1111, 1'b1, 1'b0, 1'b0},
  '{{32'hdeadbeef, 32'h008384b3, 32'h00000000, 32'h00348513},
    {32'h130, 32'h134, 32'h138, 32'h13c}, 4'b1010, 1'b1, 1'b0, 1'b1},
  '{{32'h0, 32'h0, 32'h0, 32'h0}, {32'h0, 32'h0, 32'h0, 32'h0}, 4'b0000, 1'b1, 1'b1, 1'b0},
  '{{32'h0, 32'h0, 32'h0, 32'h0}, {32'h0, 32'h0, 32'h0, 32'h0}, 4'b0000, 1'b1, 1'b1, 1'b0},
  '{{32'h004185b3, 32'hfe51ae23, 32'h00822283, 32'hffb18213},
    {32'h140, 32'h144, 32'h148, 32'h14c}, 4'b1111, 1'b1, 1'b0, 1'b1},
  '{{32'h002081b3, 32'h0, 32'h00348513, 32'h0},
    {32'h150, 32'h154, 32'h158, 32'h15c}, 4'b0101, 1'b0, 1'b0, 1'b0},
  '{{32'h00738433, 32'h008384b3, 32'h00138393, 32'habcde337},
    {32'h160, 32'h164, 32'h168, 32'h16c}, 4'b1111, 1'b0, 1'b0, 1'b0},
  '{{32'h002083b3, 32'h00138393, 32'h00738433, 32'h800000ef},
    {32'h170, 32'h174, 32'h178, 32'h17c}, 4'b1111, 1'b0, 1'b0, 1'b1},
  '{{32'h004185b3, 32'h00822283, 32'hfe51ae23, 32'h8e3086e3},
    {32'h180, 32'h184, 32'h188, 32'h18c}, 4'b1111, 1'b0, 1'b0, 1'b0},
  '{{32'hffb18213, 32'h002081b3, 32'h00108013, 32'h00000f7f},
    {32'h190, 32'h194, 32'h198, 32'h19c}, 4'b1111, 1'b1, 1'b1, 1'b0},
  '{{32'h008384b3, 32'h0, 32'h0, 32'h00348513},
    {32'h1a0, 32'h1a4, 32'h1a8, 32'h1ac}, 4'b1001, 1'b1, 1'b0, 1'b0},
  '{{32'h00738433, 32'h00138393, 32'h004185b3, 32'h00822283},
    {32'h1b0, 32'h1b4, 32'h1b8, 32'h1bc}, 4'b1111, 1'b1, 1'b0, 1'b1}
};

// File: testbench/dispatch_tb.sv
module dispatch_tb;
  import pip_types::*;

  localparam int IQ_DEPTH = 8;

  typedef struct packed {
    logic [0:3][31:0] words;
    logic [0:3][31:0] pcs;
    logic [3:0]       mask;
    logic             rdy;
    logic             ret;
    logic             rnd;
  } row_t;

  `include "dispatch_vectors.svh"

  logic        clk;
  logic        reset;
  logic [31:0] inst_word [4];
  logic [31:0] inst_pc [4];
  logic        inst_word_valid [4];
  logic        stall;
  logic        retire;
  logic        issue_ready;
  logic        issue_valid;
  iq_entry_t   issue_entry;

  bit          m_pend [32];       // reference alias table
  rob_tag_t    m_tag [32];
  rob_tag_t    m_tail = '0;
  rob_tag_t    m_head = '0;
  int          m_count = 0;
  iq_entry_t   exp_q [$];

  dispatch_top #(.IQ_DEPTH(IQ_DEPTH)) dut (
    .clk             (clk),
    .reset           (reset),
    .inst_word       (inst_word),
    .inst_pc         (inst_pc),
    .inst_word_valid (inst_word_valid),
    .stall           (stall),
    .retire          (retire),
    .issue_ready     (issue_ready),
    .issue_valid     (issue_valid),
    .issue_entry     (issue_entry)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic dec_inst_t decode_ref(logic [31:0] pc, logic [31:0] w);
    dec_inst_t   d;
    logic [31:0] imm_i;
    imm_i = $signed(w) >>> 20;
    d = '0;
    d.pc       = pc;
    d.dest_reg = w[11:7];
    d.src1_reg = w[19:15];
    d.src2_reg = w[24:20];
    case (w[6:0])
      7'h33:   d.op_class = op_alu;
      7'h13:   d.op_class = op_alu_imm;
      7'h03:   d.op_class = op_load;
      7'h23:   d.op_class = op_store;
      7'h63:   d.op_class = op_branch;
      7'h37:   d.op_class = op_lui;
      7'h6f:   d.op_class = op_jal;
      default: d.op_class = op_illegal;
    endcase
    case (d.op_class)
      op_alu_imm, op_load: d.imm = imm_i;
      op_store:  d.imm = {imm_i[31:5], w[11:7]};
      op_branch: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      op_lui:    d.imm = {w[31:12], 12'h0};
      op_jal:    d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:   d.imm = '0;
    endcase
    // rd zero and formats without rd write nothing
    d.dest_reg_valid = (w[11:7] != 5'd0) &&
                       (d.op_class inside {op_alu, op_alu_imm, op_load, op_lui, op_jal});
    d.src1_valid = d.op_class inside {op_alu, op_alu_imm, op_load, op_store, op_branch};
    d.src2_valid = d.op_class inside {op_alu, op_store, op_branch};
    return d;
  endfunction

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  task automatic apply_row(row_t v);
    for (int i = 0; i < 4; i++) begin
      inst_word[i]       = v.rnd ? {7'($urandom), v.words[i][24:0]} : v.words[i];
      inst_pc[i]         = v.rnd ? ($urandom & 32'hffff_fffc) : v.pcs[i];
      inst_word_valid[i] = v.mask[i];
    end
    issue_ready = v.rdy;
    retire      = v.ret;
  endtask

  // one clock of the reference model from 1 unit after an edge to the next
  task automatic step_cycle(output bit dispatched);
    logic       exp_stall;
    logic [3:0] mask;
    iq_entry_t  e;
    dec_inst_t  dj;
    rob_tag_t   tags [4];
    int         n;
    #1;
    mask = {inst_word_valid[3], inst_word_valid[2], inst_word_valid[1], inst_word_valid[0]};
    exp_stall = (m_count > ROB_DEPTH - 4) || (exp_q.size() > IQ_DEPTH - 4);
    check_value("stall", 128'(stall), 128'(exp_stall));
    check_value("issue_valid", 128'(issue_valid), 128'(exp_q.size() != 0));
    if (exp_q.size() != 0 && issue_ready) begin
      check_value("issue_entry", 128'(issue_entry), 128'(exp_q[0]));
      void'(exp_q.pop_front());
    end
    dispatched = !exp_stall && (mask != 4'd0);
    n = 0;
    if (dispatched) begin
      for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
          tags[i] = m_tail + rob_tag_t'(n);
          n++;
          e = '0;
          e.di = decode_ref(inst_pc[i], inst_word[i]);
          e.fwd.rob_tag      = tags[i];
          e.fwd.src1_pending = m_pend[e.di.src1_reg];
          e.fwd.src1_tag     = m_tag[e.di.src1_reg];
          e.fwd.src2_pending = m_pend[e.di.src2_reg];
          e.fwd.src2_tag     = m_tag[e.di.src2_reg];
          for (int j = 0; j < i; j++) begin
            dj = decode_ref(inst_pc[j], inst_word[j]);
            if (mask[j] && dj.dest_reg_valid && dj.dest_reg == e.di.src1_reg) begin
              e.fwd.src1_pending = 1'b1;
              e.fwd.src1_tag     = tags[j];
            end
            if (mask[j] && dj.dest_reg_valid && dj.dest_reg == e.di.src2_reg) begin
              e.fwd.src2_pending = 1'b1;
              e.fwd.src2_tag     = tags[j];
            end
          end
          e.fwd.src1_pending = e.fwd.src1_pending & e.di.src1_valid;
          e.fwd.src2_pending = e.fwd.src2_pending & e.di.src2_valid;
          if (!e.fwd.src1_pending)
            e.fwd.src1_tag = '0;
          if (!e.fwd.src2_pending)
            e.fwd.src2_tag = '0;
          exp_q.push_back(e);
        end
      end
    end
    if (retire && m_count != 0) begin   // retire clears before new marks
      for (int r = 1; r < 32; r++)
        if (m_pend[r] && m_tag[r] == m_head)
          m_pend[r] = 1'b0;
      m_head  = m_head + 1'b1;
      m_count = m_count - 1;
    end
    if (dispatched) begin
      for (int i = 0; i < 4; i++) begin
        dj = decode_ref(inst_pc[i], inst_word[i]);
        if (mask[i] && dj.dest_reg_valid) begin
          m_pend[dj.dest_reg] = 1'b1;
          m_tag[dj.dest_reg]  = tags[i];
        end
      end
      m_tail  = m_tail + rob_tag_t'(n);
      m_count = m_count + n;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    int stalled;
    bit done;
    void'($urandom(32'hc837_4a21));
    reset       = 1'b1;
    retire      = 1'b0;
    issue_ready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      inst_word[i]       = '0;
      inst_pc[i]         = '0;
      inst_word_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    for (int r = 0; r < N_ROWS; r++) begin
      apply_row(vectors[r]);
      stalled = 0;
      done    = 1'b0;
      while (!done) begin
        step_cycle(done);
        retire = 1'b0;
        stalled++;
        if (vectors[r].mask == 4'd0)
          done = 1'b1;
        else if (stalled > 100)
          abort_run("timeout: a held group never left stall");
        else if (!done && stalled >= 8)
          retire = 1'b1;              // free rob tags
        if (!done && stalled >= 4)
          issue_ready = 1'b1;         // drain the queue
      end
    end

    for (int i = 0; i < 4; i++)
      inst_word_valid[i] = 1'b0;
    issue_ready = 1'b1;
    stalled = 0;
    while (exp_q.size() != 0) begin
      step_cycle(done);
      stalled++;
      if (stalled > 50)
        abort_run("timeout: expected entries were never issued");
    end
    step_cycle(done);                 // queue must read empty
    $display("** PASS **");
    $finish;
  end

endmodule

// File: hw/dispatch_top.sv
module dispatch_top #(
  parameter int IQ_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [31:0]          inst_word [4],
  input  logic [31:0]          inst_pc [4],
  input  logic                 inst_word_valid [4],
  output logic                 stall,
  input  logic                 retire,
  input  logic                 issue_ready,
  output logic                 issue_valid,
  output pip_types::iq_entry_t issue_entry
);
  import pip_types::*;

  logic [4:0] dest_reg [4];
  logic       dest_reg_valid [4];
  logic [4:0] src1_reg [4];
  logic       src1_valid [4];
  logic [4:0] src2_reg [4];
  logic       src2_valid [4];
  fwd_info_t  fwd_info [4];
  rob_tag_t   reserved_slots [4];
  rob_tag_t   head_tag;
  logic       rob_full;
  logic       reserve;
  logic [1:0] reserve_count;
  logic       ins_enable;
  logic [1:0] new_count;
  iq_entry_t  new_elements [4];
  logic       iq_full;

  dispatch_stage u_dispatch (
    .inst_word       (inst_word),
    .inst_pc         (inst_pc),
    .inst_word_valid (inst_word_valid),
    .stall           (stall),
    .dest_reg        (dest_reg),
    .dest_reg_valid  (dest_reg_valid),
    .src1_reg        (src1_reg),
    .src1_valid      (src1_valid),
    .src2_reg        (src2_reg),
    .src2_valid      (src2_valid),
    .fwd_info        (fwd_info),
    .reserve         (reserve),
    .reserve_count   (reserve_count),
    .rob_full        (rob_full),
    .ins_enable      (ins_enable),
    .new_count       (new_count),
    .new_elements    (new_elements),
    .iq_full         (iq_full)
  );

  fwd_table u_fwd (
    .clk            (clk),
    .reset          (reset),
    .dest_reg       (dest_reg),
    .dest_reg_valid (dest_reg_valid),
    .src1_reg       (src1_reg),
    .src1_valid     (src1_valid),
    .src2_reg       (src2_reg),
    .src2_valid     (src2_valid),
    .lane_valid     (inst_word_valid),
    .reserve        (reserve),
    .reserved_slots (reserved_slots),
    .retire         (retire),
    .head_tag       (head_tag),
    .fwd_info       (fwd_info)
  );

  rob_alloc u_rob (
    .clk            (clk),
    .reset          (reset),
    .lane_valid     (inst_word_valid),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .retire         (retire),
    .reserved_slots (reserved_slots),
    .head_tag       (head_tag),
    .rob_full       (rob_full)
  );

  issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_iq (
    .clk          (clk),
    .reset        (reset),
    .ins_enable   (ins_enable),
    .new_count    (new_count),
    .new_elements (new_elements),
    .iq_full      (iq_full),
    .issue_ready  (issue_ready),
    .issue_valid  (issue_valid),
    .issue_entry  (issue_entry)
  );

endmodule

// File: hw/issue_queue.sv
module issue_queue #(
  parameter int IQ_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ins_enable,
  input  logic [1:0]           new_count,
  input  pip_types::iq_entry_t new_elements [4],
  output logic                 iq_full,
  input  logic                 issue_ready,
  output logic                 issue_valid,
  output pip_types::iq_entry_t issue_entry
);
  import pip_types::*;

  localparam int PTR_W = $clog2(IQ_DEPTH);
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);
  localparam logic [PTR_W:0]   DEPTH_P   = (PTR_W+1)'(IQ_DEPTH);
  localparam logic [CNT_W-1:0] FULL_MARK = CNT_W'(IQ_DEPTH - 4);

  iq_entry_t        mem [IQ_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  logic [2:0]       add_n;
  logic             pop;

  // depth need not be a power of two
  function automatic logic [PTR_W-1:0] wrap_add(logic [PTR_W-1:0] p, logic [2:0] k);
    logic [PTR_W:0] s;
    s = {1'b0, p} + (PTR_W+1)'(k);
    if (s >= DEPTH_P)
      s = s - DEPTH_P;
    return s[PTR_W-1:0];
  endfunction

  assign add_n       = ins_enable ? {1'b0, new_count} + 3'd1 : 3'd0;
  assign issue_valid = count_q != '0;
  assign issue_entry = mem[head_q];
  assign pop         = issue_valid & issue_ready;
  assign iq_full     = count_q > FULL_MARK;   // room for a whole group

  always_ff @(posedge clk) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      tail_q  <= wrap_add(tail_q, add_n);
      head_q  <= wrap_add(head_q, {2'b0, pop});
      count_q <= count_q + CNT_W'(add_n) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (ins_enable) begin
      for (int k = 0; k < 4; k++)
        if (k <= int'(new_count))
          mem[wrap_add(tail_q, 3'(k))] <= new_elements[k];
    end
  end

endmodule

// File: hw/dispatch_stage.sv
module dispatch_stage (
  input  logic [31:0]           inst_word [4],
  input  logic [31:0]           inst_pc [4],
  input  logic                  inst_word_valid [4],
  output logic                  stall,
  output logic [4:0]            dest_reg [4],
  output logic                  dest_reg_valid [4],
  output logic [4:0]            src1_reg [4],
  output logic                  src1_valid [4],
  output logic [4:0]            src2_reg [4],
  output logic                  src2_valid [4],
  input  pip_types::fwd_info_t  fwd_info [4],
  output logic                  reserve,
  output logic [1:0]            reserve_count,
  input  logic                  rob_full,
  output logic                  ins_enable,
  output logic [1:0]            new_count,
  output pip_types::iq_entry_t  new_elements [4],
  input  logic                  iq_full
);
  import pip_types::*;

  dec_inst_t  dec_inst [4];
  logic [2:0] n_valid;
  logic       any_valid;
  logic [1:0] slot;

  for (genvar i = 0; i < 4; i++) begin : g_lane
    inst_decoder u_dec (
      .pc        (inst_pc[i]),
      .inst_word (inst_word[i]),
      .di        (dec_inst[i])
    );

    assign dest_reg[i]       = dec_inst[i].dest_reg;
    assign dest_reg_valid[i] = dec_inst[i].dest_reg_valid;
    assign src1_reg[i]       = dec_inst[i].src1_reg;
    assign src1_valid[i]     = dec_inst[i].src1_valid;
    assign src2_reg[i]       = dec_inst[i].src2_reg;
    assign src2_valid[i]     = dec_inst[i].src2_valid;
  end

  always_comb begin
    n_valid = 3'd0;
    for (int i = 0; i < 4; i++)
      n_valid = n_valid + {2'b0, inst_word_valid[i]};
  end

  assign any_valid     = n_valid != 3'd0;
  assign reserve_count = n_valid[1:0] - 2'd1;   // count minus one, 4 wraps to 3
  assign new_count     = reserve_count;

  assign stall      = rob_full | iq_full;
  assign reserve    = ~stall & any_valid;
  assign ins_enable = ~stall & any_valid;

  // pack valid lanes to the front, lane order kept
  always_comb begin
    slot = 2'd0;
    for (int k = 0; k < 4; k++)
      new_elements[k] = '0;
    for (int i = 0; i < 4; i++) begin
      if (inst_word_valid[i]) begin
        new_elements[slot] = '{di: dec_inst[i], fwd: fwd_info[i]};
        slot = slot + 2'd1;
      end
    end
  end

endmodule

// File: hw/rob_alloc.sv
module rob_alloc (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lane_valid [4],
  input  logic                 reserve,
  input  logic [1:0]           reserve_count,
  input  logic                 retire,
  output pip_types::rob_tag_t  reserved_slots [4],
  output pip_types::rob_tag_t  head_tag,
  output logic                 rob_full
);
  import pip_types::*;

  localparam logic [ROB_DEPTHLOG2:0] FULL_MARK = (ROB_DEPTHLOG2+1)'(ROB_DEPTH - 4);

  rob_tag_t               head_q;
  rob_tag_t               tail_q;
  logic [ROB_DEPTHLOG2:0] count_q;
  logic [2:0]             add_n;
  logic                   retire_ok;
  logic [2:0]             prefix;

  // lane i gets tail plus number of valid lanes below it
  always_comb begin
    prefix = 3'd0;
    for (int i = 0; i < 4; i++) begin
      reserved_slots[i] = tail_q + rob_tag_t'(prefix);
      if (lane_valid[i])
        prefix = prefix + 3'd1;
    end
  end

  assign add_n     = reserve ? {1'b0, reserve_count} + 3'd1 : 3'd0;
  assign retire_ok = retire & (count_q != '0);   // empty rob ignores retire
  assign head_tag  = head_q;
  assign rob_full  = count_q > FULL_MARK;        // fewer than four free

  always_ff @(posedge clk) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      tail_q  <= tail_q + rob_tag_t'(add_n);
      head_q  <= head_q + rob_tag_t'(retire_ok);
      count_q <= count_q + (ROB_DEPTHLOG2+1)'(add_n)
                 - (ROB_DEPTHLOG2+1)'(retire_ok);
    end
  end

endmodule

// File: hw/fwd_table.sv
module fwd_table (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [4:0]            dest_reg [4],
  input  logic                  dest_reg_valid [4],
  input  logic [4:0]            src1_reg [4],
  input  logic                  src1_valid [4],
  input  logic [4:0]            src2_reg [4],
  input  logic                  src2_valid [4],
  input  logic                  lane_valid [4],
  input  logic                  reserve,
  input  pip_types::rob_tag_t   reserved_slots [4],
  input  logic                  retire,
  input  pip_types::rob_tag_t   head_tag,
  output pip_types::fwd_info_t  fwd_info [4]
);
  import pip_types::*;

  logic [31:0] pend_q;
  rob_tag_t    tag_q [32];
  logic        lane_writes [4];

  always_comb begin
    for (int i = 0; i < 4; i++)
      lane_writes[i] = lane_valid[i] & dest_reg_valid[i] & (dest_reg[i] != 5'd0);
  end

  // table value first, then lower lanes in order so the nearest writer wins
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      fwd_info[i].rob_tag      = reserved_slots[i];
      fwd_info[i].src1_pending = pend_q[src1_reg[i]];
      fwd_info[i].src1_tag     = tag_q[src1_reg[i]];
      fwd_info[i].src2_pending = pend_q[src2_reg[i]];
      fwd_info[i].src2_tag     = tag_q[src2_reg[i]];
      for (int j = 0; j < i; j++) begin
        if (lane_writes[j] && dest_reg[j] == src1_reg[i]) begin
          fwd_info[i].src1_pending = 1'b1;
          fwd_info[i].src1_tag     = reserved_slots[j];
        end
        if (lane_writes[j] && dest_reg[j] == src2_reg[i]) begin
          fwd_info[i].src2_pending = 1'b1;
          fwd_info[i].src2_tag     = reserved_slots[j];
        end
      end
      fwd_info[i].src1_pending &= src1_valid[i];  // unused source never waits
      fwd_info[i].src2_pending &= src2_valid[i];
      if (!fwd_info[i].src1_pending)
        fwd_info[i].src1_tag = '0;
      if (!fwd_info[i].src2_pending)
        fwd_info[i].src2_tag = '0;
    end
  end

  // retire clears first, dispatch marks override it
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= '0;
    end else begin
      if (retire) begin
        for (int r = 1; r < 32; r++)
          if (pend_q[r] && tag_q[r] == head_tag)
            pend_q[r] <= 1'b0;
      end
      if (reserve) begin
        for (int i = 0; i < 4; i++)
          if (lane_writes[i])
            pend_q[dest_reg[i]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reserve) begin
      for (int i = 0; i < 4; i++)
        if (lane_writes[i])
          tag_q[dest_reg[i]] <= reserved_slots[i];  // later lane wins
    end
  end

endmodule

// File: hw/inst_decoder.sv
module inst_decoder (
  input  logic [31:0]          pc,
  input  logic [31:0]          inst_word,
  output pip_types::dec_inst_t di
);
  import pip_types::*;

  logic [6:0]  opcode;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = inst_word[6:0];

  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'b0};
  assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                  inst_word[20], inst_word[30:21], 1'b0};

  always_comb begin
    di                = '0;
    di.pc             = pc;
    di.dest_reg       = inst_word[11:7];
    di.src1_reg       = inst_word[19:15];
    di.src2_reg       = inst_word[24:20];
    di.op_class       = op_illegal;
    case (opcode)
      OPC_OP: begin
        di.op_class       = op_alu;
        di.dest_reg_valid = 1'b1;
        di.src1_valid     = 1'b1;
        di.src2_valid     = 1'b1;
      end
      OPC_OP_IMM: begin
        di.op_class       = op_alu_imm;
        di.dest_reg_valid = 1'b1;
        di.src1_valid     = 1'b1;
        di.imm            = imm_i;
      end
      OPC_LOAD: begin
        di.op_class       = op_load;
        di.dest_reg_valid = 1'b1;
        di.src1_valid     = 1'b1;
        di.imm            = imm_i;
      end
      OPC_STORE: begin
        di.op_class       = op_store;
        di.src1_valid     = 1'b1;   // base
        di.src2_valid     = 1'b1;   // store data
        di.imm            = imm_s;
      end
      OPC_BRANCH: begin
        di.op_class       = op_branch;
        di.src1_valid     = 1'b1;
        di.src2_valid     = 1'b1;
        di.imm            = imm_b;
      end
      OPC_LUI: begin
        di.op_class       = op_lui;
        di.dest_reg_valid = 1'b1;
        di.imm            = imm_u;
      end
      OPC_JAL: begin
        di.op_class       = op_jal;
        di.dest_reg_valid = 1'b1;
        di.imm            = imm_j;
      end
      default: di.op_class = op_illegal;
    endcase
    if (inst_word[11:7] == 5'd0)
      di.dest_reg_valid = 1'b0;     // x0 writes are dropped
  end

endmodule

// File: hw/pip_types.sv
package pip_types;

  localparam int ROB_DEPTHLOG2 = 4;
  localparam int ROB_DEPTH     = 1 << ROB_DEPTHLOG2;

  // rv32i major opcodes handled by the decoder
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef logic [ROB_DEPTHLOG2-1:0] rob_tag_t;

  typedef enum logic [2:0] {
    op_alu,
    op_alu_imm,
    op_load,
    op_store,
    op_branch,
    op_lui,
    op_jal,
    op_illegal
  } op_class_t;

  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op_class;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic [4:0]  src1_reg;
    logic        src1_valid;
    logic [4:0]  src2_reg;
    logic        src2_valid;
    logic [31:0] imm;       // sign-extended per format
  } dec_inst_t;

  typedef struct packed {
    rob_tag_t rob_tag;      // own reserved slot
    logic     src1_pending;
    rob_tag_t src1_tag;
    logic     src2_pending;
    rob_tag_t src2_tag;
  } fwd_info_t;

  // decoded record in the upper bits, forwarding info below
  typedef struct packed {
    dec_inst_t di;
    fwd_info_t fwd;
  } iq_entry_t;

endpackage
